// ==== dcache_top.f ====
verilog/dcache_geom_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_sram.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

// ==== tb/dcache_checker.sv ====
/*
 * Data cache protocol checker
 * Bound into the cache top level, watches the CPU ack and the
 * memory side strobes
 */
`timescale 1ns/1ps

module dcache_checker (
   input logic clk,
   input logic rst,
   input logic cpu_busy_i,
   input logic cpu_ack_i,
   input logic mem_wr_valid_i,
   input logic mem_rd_req_i
);

   // Number of assertion failures so far
   int fail_cnt = 0;

   // Ack is a single-cycle strobe
   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_i |=> !cpu_ack_i)
   else begin
      fail_cnt++;
      $error("cpu_ack_o stayed high for more than one cycle");
   end

   // Write-back finishes before the refill request
   wr_rd_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(mem_wr_valid_i && mem_rd_req_i))
   else begin
      fail_cnt++;
      $error("mem_wr_valid_o and mem_rd_req_o high in the same cycle");
   end

   ack_while_busy: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_i |-> cpu_busy_i)
   else begin
      fail_cnt++;
      $error("cpu_ack_o seen while cpu_busy_o was low");
   end

endmodule

bind dcache_top dcache_checker u_dcache_checker (
   .clk            (clk),
   .rst            (rst),
   .cpu_busy_i     (cpu_busy_o),
   .cpu_ack_i      (cpu_ack_o),
   .mem_wr_valid_i (mem_wr_valid_o),
   .mem_rd_req_i   (mem_rd_req_o)
);

// ==== tb/tb_dcache.sv ====
/*
 * Data cache testbench
 * Random loads, stores and invalidates over a small address pool,
 * backing memory responder and a reference model of the CPU view
 */
`timescale 1ns/1ps

module tb_dcache;
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_OPS    = 400;
   localparam int POOL_SIZE  = 24;
   // Lookup, dump, refill with worst gaps, slack
   localparam int OP_CYCLES  = 8 + 8 + 8 * 4 + 10;

   logic                  clk;
   logic                  rst;
   logic                  cpu_req_valid;
   cpu_req_t              cpu_req;
   logic                  cpu_busy;
   logic                  cpu_ack;
   logic [DATA_WIDTH-1:0] cpu_rdata;
   logic                  mem_wr_valid;
   mem_wr_t               mem_wr;
   logic                  mem_rd_req;
   logic [ADDR_WIDTH-1:0] mem_rd_addr;
   logic                  mem_rd_valid;
   logic [DATA_WIDTH-1:0] mem_rd_data;

   // Reference model
   // Backing memory plus every word stored since its set was last invalidated
   logic [31:0] backing [logic [31:0]];
   logic [31:0] view [logic [31:0]];
   logic [31:0] pool [POOL_SIZE];
   logic [31:0] cur_addr;
   logic [31:0] wb_base;
   int          errors;
   int          n_ops;
   int          wr_strobes;
   int          rd_reqs;
   int          wb_idx;
   int          cycle;
   int          last_wb_cycle;

   dcache_top u_dcache_top (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_valid_i (cpu_req_valid),
      .cpu_req_i       (cpu_req),
      .cpu_busy_o      (cpu_busy),
      .cpu_ack_o       (cpu_ack),
      .cpu_rdata_o     (cpu_rdata),
      .mem_wr_valid_o  (mem_wr_valid),
      .mem_wr_o        (mem_wr),
      .mem_rd_req_o    (mem_rd_req),
      .mem_rd_addr_o   (mem_rd_addr),
      .mem_rd_valid_i  (mem_rd_valid),
      .mem_rd_data_i   (mem_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ****************************************
   // Model helpers
   // ****************************************
   function automatic logic [31:0] line_base(input logic [31:0] addr);
      return {addr[31:5], 5'b0};
   endfunction

   function automatic logic [5:0] set_of(input logic [31:0] addr);
      return addr[10:5];
   endfunction

   // Untouched memory holds a pattern of its own address
   function automatic logic [31:0] backing_word(input logic [31:0] addr);
      if (backing.exists(addr)) begin
         return backing[addr];
      end
      return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
   endfunction

   function automatic logic [31:0] expected_word(input logic [31:0] addr);
      if (view.exists(addr)) begin
         return view[addr];
      end
      return backing_word(addr);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  bsel);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Invalidate drops dirty data, so the set falls back to memory
   task automatic forget_set(input logic [5:0] set);
      logic [31:0] keys [$];
      foreach (view[k]) begin
         if (set_of(k) == set) begin
            keys.push_back(k);
         end
      end
      foreach (keys[i]) begin
         view.delete(keys[i]);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
   endtask

   // One CPU request, entered and left on a falling edge
   task automatic do_op(input cache_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] bsel,
                        output int lat, output logic [31:0] rdata);
      while (cpu_busy) begin
         @(negedge clk);
      end
      cur_addr      = addr;
      cpu_req.op    = op;
      cpu_req.addr  = addr;
      cpu_req.wdata = wdata;
      cpu_req.bsel  = bsel;
      cpu_req_valid = 1'b1;
      @(negedge clk);
      cpu_req_valid = 1'b0;
      lat = 1;
      while (!cpu_ack) begin
         @(negedge clk);
         lat++;
      end
      rdata = cpu_rdata;
      n_ops++;
   endtask

   // ****************************************
   // Memory side monitor and responder
   // ****************************************
   always @(negedge clk) begin
      cycle++;
      if (!rst && mem_wr_valid) begin
         if (wb_idx == 0) begin
            wb_base = line_base(mem_wr.addr);
         end else if (cycle != last_wb_cycle + 1) begin
            errors++;
            $display("Write-back strobes did not come on consecutive cycles");
         end
         if (mem_wr.addr !== wb_base + 4 * wb_idx) begin
            report_mismatch("writeback address", wb_base + 4 * wb_idx, mem_wr.addr);
         end
         if (set_of(mem_wr.addr) !== set_of(cur_addr)) begin
            report_mismatch("writeback set", set_of(cur_addr), set_of(mem_wr.addr));
         end
         if (mem_wr.data !== expected_word(mem_wr.addr)) begin
            report_mismatch("writeback data", expected_word(mem_wr.addr), mem_wr.data);
         end
         backing[mem_wr.addr] = mem_wr.data;
         last_wb_cycle = cycle;
         wb_idx = (wb_idx + 1) % 8;
         wr_strobes++;
      end
      if (!rst && mem_rd_req) begin
         if (mem_rd_addr !== line_base(cur_addr)) begin
            report_mismatch("refill address", line_base(cur_addr), mem_rd_addr);
         end
         if (wb_idx != 0) begin
            errors++;
            $display("Refill requested before the write-back of 8 words finished");
         end
         rd_reqs++;
      end
   end

   // Returns 8 words, each after a gap of 0 to 3 cycles
   initial begin : responder
      logic [31:0] base;
      int          gap;
      forever begin
         @(negedge clk);
         if (!rst && mem_rd_req) begin
            base = mem_rd_addr;
            @(negedge clk);
            for (int w = 0; w < 8; w++) begin
               gap = $urandom % 4;
               repeat (gap) @(negedge clk);
               mem_rd_valid = 1'b1;
               mem_rd_data  = backing_word(base + 4 * w);
               @(negedge clk);
               mem_rd_valid = 1'b0;
            end
         end
      end
   end

   initial begin : watchdog
      #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before all operations completed");
      $display("STATUS: FAIL");
      $finish;
   end

   // ****************************************
   // Stimulus and checks
   // ****************************************
   initial begin : stimulus
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic [31:0] exp;
      logic [3:0]  bsel;
      int          sel;
      int          lat;
      int          wr0;
      int          rd0;
      int          i;
      void'($urandom(17));
      rst           = 1'b1;
      cpu_req_valid = 1'b0;
      cpu_req       = '0;
      mem_rd_valid  = 1'b0;
      mem_rd_data   = '0;
      // 3 sets, 4 tags per set, 2 words per line
      for (i = 0; i < POOL_SIZE; i++) begin
         pool[i] = {TAG_WIDTH'(32'h15a3 * (i / 2 % 4 + 1)), SET_WIDTH'(5 + 19 * (i / 8)),
                    WORD_SEL_WIDTH'(i / 2 % 4 + 4 * (i % 2)), 2'b00};
      end
      repeat (10) @(negedge clk);
      rst = 1'b0;
      if (cpu_busy !== 1'b0 || cpu_ack !== 1'b0 || mem_wr_valid !== 1'b0 ||
          mem_rd_req !== 1'b0) begin
         errors++;
         $display("Cache outputs were not idle after reset");
      end

      // Cold cache, so the first load refills without a write-back
      exp = expected_word(pool[0]);
      do_op(OP_LOAD, pool[0], '0, '0, lat, rdata);
      if (rd_reqs != 1 || wr_strobes != 0) begin
         errors++;
         $display("First load did not refill with one request and no write-back");
      end
      if (rdata !== exp) begin
         report_mismatch("first load data", exp, rdata);
      end

      while (n_ops < NUM_OPS) begin
         sel  = $urandom % 16;
         addr = pool[$urandom % POOL_SIZE];
         if (sel < 7) begin
            exp = expected_word(addr);
            do_op(OP_LOAD, addr, '0, '0, lat, rdata);
            if (rdata !== exp) begin
               report_mismatch("load data", exp, rdata);
            end
            // Line was just filled or hit, a second load must hit
            if ($urandom % 4 == 0) begin
               wr0 = wr_strobes;
               rd0 = rd_reqs;
               do_op(OP_LOAD, addr, '0, '0, lat, rdata);
               if (lat != 2) begin
                  report_mismatch("repeat load latency", 32'd2, lat);
               end
               if (rdata !== exp) begin
                  report_mismatch("repeat load data", exp, rdata);
               end
               if (wr_strobes != wr0 || rd_reqs != rd0) begin
                  errors++;
                  $display("Repeated load to a cached line caused memory traffic");
               end
            end
         end else if (sel < 15) begin
            wdata = $urandom;
            bsel  = 4'($urandom % 15 + 1);
            exp   = merge_bytes(expected_word(addr), wdata, bsel);
            do_op(OP_STORE, addr, wdata, bsel, lat, rdata);
            view[addr] = exp;
         end else begin
            do_op(OP_INVAL, addr, '0, '0, lat, rdata);
            if (lat != 2) begin
               report_mismatch("invalidate latency", 32'd2, lat);
            end
            forget_set(set_of(addr));
            // Whole set reads back from memory now
            for (i = 0; i < POOL_SIZE; i++) begin
               if (set_of(pool[i]) == set_of(addr)) begin
                  exp = backing_word(pool[i]);
                  do_op(OP_LOAD, pool[i], '0, '0, lat, rdata);
                  if (rdata !== exp) begin
                     report_mismatch("load after invalidate", exp, rdata);
                  end
               end
            end
         end
      end

      @(negedge clk);
      errors += u_dcache_top.u_dcache_checker.fail_cnt;
      $display("Operations: %0d, write-back strobes: %0d, refills: %0d, errors: %0d",
               n_ops, wr_strobes, rd_reqs, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog/dcache_bus_pkg.sv ====
/*
 * Data cache bus types
 * CPU request opcodes and payloads on the CPU and memory sides
 */
package dcache_bus_pkg;

   // CPU opcodes
   typedef enum logic [1:0] {
      OP_LOAD,
      OP_STORE,
      OP_INVAL
   } cache_op_e;

   // One CPU request, valid with its strobe
   typedef struct packed {
      cache_op_e                                op;
      dcache_geom_pkg::addr_fields_t            addr;
      logic [dcache_geom_pkg::DATA_WIDTH-1:0]   wdata;
      // Byte lanes, bit 0 is bits 7:0
      logic [3:0]                               bsel;
   } cpu_req_t;

   // One write-back word toward memory
   typedef struct packed {
      logic [dcache_geom_pkg::ADDR_WIDTH-1:0] addr;
      logic [dcache_geom_pkg::DATA_WIDTH-1:0] data;
   } mem_wr_t;

endpackage

// ==== verilog/dcache_ctrl.sv ====
/*
 * Data cache controller
 * FSM for lookup, victim dump and refill with replay; holds the
 * request register and the dump and refill word counters
 */
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic                                       clk,
   input  logic                                       rst,
   // CPU side
   input  logic                                       cpu_req_valid_i,
   input  dcache_bus_pkg::cpu_req_t                   cpu_req_i,
   output logic                                       cpu_busy_o,
   output logic                                       cpu_ack_o,
   output logic [dcache_geom_pkg::DATA_WIDTH-1:0]     cpu_rdata_o,
   // Array read index and way select
   output dcache_geom_pkg::addr_fields_t              rd_addr_o,
   output logic                                       way_o,
   // Array write commands
   output logic [dcache_geom_pkg::SET_WIDTH-1:0]      wr_set_o,
   output logic [dcache_geom_pkg::TAG_WIDTH-1:0]      wr_tag_o,
   output logic                                       tag_wr_o,
   output logic                                       dirty_set_o,
   output logic                                       clear_set_o,
   output logic                                       touch_o,
   output logic                                       data_wr_o,
   output logic [dcache_geom_pkg::WORD_SEL_WIDTH-1:0] data_wr_word_o,
   output logic [dcache_geom_pkg::DATA_WIDTH-1:0]     data_wr_data_o,
   output logic [3:0]                                 data_wr_bsel_o,
   // Array results
   input  logic                                       hit_i,
   input  logic                                       hit_way_i,
   input  logic                                       victim_way_i,
   input  logic                                       victim_dirty_i,
   input  logic [dcache_geom_pkg::TAG_WIDTH-1:0]      victim_tag_i,
   input  logic [dcache_geom_pkg::DATA_WIDTH-1:0]     data_rdata_i,
   // Memory side
   output logic                                       mem_wr_valid_o,
   output dcache_bus_pkg::mem_wr_t                    mem_wr_o,
   output logic                                       mem_rd_req_o,
   output logic [dcache_geom_pkg::ADDR_WIDTH-1:0]     mem_rd_addr_o,
   input  logic                                       mem_rd_valid_i,
   input  logic [dcache_geom_pkg::DATA_WIDTH-1:0]     mem_rd_data_i
);
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_DUMP, ST_REFILL} state_e;

   state_e                    state_q;
   cpu_req_t                  req_q;
   logic                      victim_way_q;
   logic [TAG_WIDTH-1:0]      victim_tag_q;
   // Dump reads issued and write strobes sent, bit 3 marks all 8
   logic [3:0]                dump_rd_cnt_q;
   logic [3:0]                dump_wr_cnt_q;
   logic                      dump_rd_pend_q;
   logic [WORD_SEL_WIDTH-1:0] refill_cnt_q;
   logic                      busy_q;
   logic                      ack_q;
   logic [DATA_WIDTH-1:0]     rdata_q;
   logic                      mem_wr_valid_q;
   mem_wr_t                   mem_wr_q;
   logic                      mem_rd_req_q;
   logic                      lookup;
   logic                      dump_issue;
   logic                      refill_beat;
   logic                      refill_last;

   assign lookup      = state_q == ST_LOOKUP;
   assign dump_issue  = state_q == ST_DUMP && !dump_rd_cnt_q[3];
   assign refill_beat = state_q == ST_REFILL && mem_rd_valid_i;
   assign refill_last = refill_beat && refill_cnt_q == '1;

   // Incoming address while idle, held request otherwise
   // Dump walks the words of the victim line
   always_comb begin
      rd_addr_o = (state_q == ST_IDLE) ? cpu_req_i.addr : req_q.addr;
      if (state_q == ST_DUMP) begin
         rd_addr_o.word = dump_rd_cnt_q[2:0];
      end
   end

   // Hit way during lookup, latched victim during dump and refill
   assign way_o = lookup ? hit_way_i : victim_way_q;

   // ****************************************
   // Array write commands
   // ****************************************
   assign wr_set_o    = req_q.addr.set;
   assign wr_tag_o    = req_q.addr.tag;
   assign tag_wr_o    = refill_last;
   assign touch_o     = lookup && hit_i && req_q.op != OP_INVAL;
   assign dirty_set_o = lookup && hit_i && req_q.op == OP_STORE;
   // Invalidate drops the set without writing dirty data back
   assign clear_set_o = lookup && req_q.op == OP_INVAL;

   assign data_wr_o      = dirty_set_o || refill_beat;
   assign data_wr_word_o = lookup ? req_q.addr.word : refill_cnt_q;
   assign data_wr_data_o = lookup ? req_q.wdata : mem_rd_data_i;
   assign data_wr_bsel_o = lookup ? req_q.bsel : 4'hf;

   // ****************************************
   // FSM and counters
   // ****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q        <= ST_IDLE;
         busy_q         <= 1'b0;
         ack_q          <= 1'b0;
         mem_wr_valid_q <= 1'b0;
         mem_rd_req_q   <= 1'b0;
         dump_rd_cnt_q  <= '0;
         dump_wr_cnt_q  <= '0;
         dump_rd_pend_q <= 1'b0;
         refill_cnt_q   <= '0;
      end else begin
         ack_q          <= 1'b0;
         mem_rd_req_q   <= 1'b0;
         // Word read one cycle ago goes out as a strobe now
         dump_rd_pend_q <= dump_issue;
         mem_wr_valid_q <= dump_rd_pend_q;
         if (cpu_ack_o) begin
            busy_q <= 1'b0;
         end
         if (dump_issue) begin
            dump_rd_cnt_q <= dump_rd_cnt_q + 4'd1;
         end
         if (dump_rd_pend_q) begin
            dump_wr_cnt_q <= dump_wr_cnt_q + 4'd1;
         end
         // Wraps back to zero after the 8th word
         if (refill_beat) begin
            refill_cnt_q <= refill_cnt_q + 1'b1;
         end

         case (state_q)
            ST_IDLE: begin
               if (cpu_req_valid_i) begin
                  busy_q  <= 1'b1;
                  state_q <= ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               if (hit_i || req_q.op == OP_INVAL) begin
                  ack_q   <= 1'b1;
                  state_q <= ST_IDLE;
               end else if (victim_dirty_i) begin
                  dump_rd_cnt_q <= '0;
                  dump_wr_cnt_q <= '0;
                  state_q       <= ST_DUMP;
               end else begin
                  mem_rd_req_q <= 1'b1;
                  state_q      <= ST_REFILL;
               end
            end
            ST_DUMP: begin
               // Last strobe is on the bus, refill request follows it
               if (dump_wr_cnt_q[3]) begin
                  mem_rd_req_q <= 1'b1;
                  state_q      <= ST_REFILL;
               end
            end
            ST_REFILL: begin
               // Replay so the request finishes on the hit path
               if (refill_last) begin
                  state_q <= ST_LOOKUP;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Request, victim and data payload
   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && cpu_req_valid_i) begin
         req_q <= cpu_req_i;
      end
      if (lookup && !hit_i) begin
         victim_way_q <= victim_way_i;
         victim_tag_q <= victim_tag_i;
      end
      if (lookup) begin
         rdata_q <= data_rdata_i;
      end
      if (dump_rd_pend_q) begin
         mem_wr_q.addr <= {victim_tag_q, req_q.addr.set, dump_wr_cnt_q[2:0], 2'b00};
         mem_wr_q.data <= data_rdata_i;
      end
   end

   // Outputs
   assign cpu_busy_o     = busy_q;
   assign cpu_ack_o      = ack_q;
   assign cpu_rdata_o    = rdata_q;
   assign mem_wr_valid_o = mem_wr_valid_q;
   assign mem_wr_o       = mem_wr_q;
   assign mem_rd_req_o   = mem_rd_req_q;
   // Line base of the request
   assign mem_rd_addr_o  = {req_q.addr.tag, req_q.addr.set, {(WORD_SEL_WIDTH + 2){1'b0}}};

endmodule

// ==== verilog/dcache_data_array.sv ====
/*
 * Data cache data array
 * Line data RAM per way, byte merge for stores and
 * way select on the read output
 */
`timescale 1ns/1ps

module dcache_data_array #(
   parameter int RAM_AW = dcache_geom_pkg::SET_WIDTH + dcache_geom_pkg::WORD_SEL_WIDTH,
   parameter int RAM_DW = dcache_geom_pkg::DATA_WIDTH
) (
   input  logic                                       clk,
   input  logic [dcache_geom_pkg::SET_WIDTH-1:0]      rd_set_i,
   input  logic [dcache_geom_pkg::WORD_SEL_WIDTH-1:0] rd_word_i,
   input  logic                                       out_way_i,
   input  logic                                       wr_en_i,
   input  logic                                       wr_way_i,
   input  logic [dcache_geom_pkg::SET_WIDTH-1:0]      wr_set_i,
   input  logic [dcache_geom_pkg::WORD_SEL_WIDTH-1:0] wr_word_i,
   input  logic [dcache_geom_pkg::DATA_WIDTH-1:0]     wr_data_i,
   input  logic [3:0]                                 wr_bsel_i,
   output logic [dcache_geom_pkg::DATA_WIDTH-1:0]     rdata_o
);
   import dcache_geom_pkg::*;

   // Read data of each way, one cycle after the read address
   logic [RAM_DW-1:0] way_rdata [NUM_WAYS];
   // Word currently held by the written way and the merged result
   logic [RAM_DW-1:0] old_word;
   logic [RAM_DW-1:0] merged;

   // Old word comes from the read issued one cycle earlier at the same address
   assign old_word = way_rdata[wr_way_i];

   // Byte lane merge
   // Refill drives all lanes so the old word drops out
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = wr_bsel_i[b] ? wr_data_i[8*b +: 8] : old_word[8*b +: 8];
      end
   end

   // ****************************************
   // Data RAMs, addressed by set and word
   // ****************************************
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sram #(
         .ADDR_W (RAM_AW),
         .DATA_W (RAM_DW)
      ) u_data_ram (
         .clk     (clk),
         .raddr_i ({rd_set_i, rd_word_i}),
         .waddr_i ({wr_set_i, wr_word_i}),
         .we_i    (wr_en_i && wr_way_i == 1'(w)),
         .wdata_i (merged),
         .rdata_o (way_rdata[w])
      );
   end

   // Hit way on lookup, victim way on dump
   assign rdata_o = way_rdata[out_way_i];

endmodule

// ==== verilog/dcache_geom_pkg.sv ====
/*
 * Data cache geometry
 * Address split, way count and tag RAM entry layout for the
 * two-way write-back data cache
 */
package dcache_geom_pkg;

   // Byte address and data word widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;

   // 8 words per 32-byte line
   localparam int WORD_SEL_WIDTH = 3;

   // 64 sets
   localparam int SET_WIDTH = 6;

   // Whatever is left above set, word and byte offset
   localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - WORD_SEL_WIDTH - 2;

   localparam int NUM_WAYS = 2;

   // Byte address viewed as cache fields, MSB first
   typedef struct packed {
      logic [TAG_WIDTH-1:0]      tag;
      logic [SET_WIDTH-1:0]      set;
      logic [WORD_SEL_WIDTH-1:0] word;
      logic [1:0]                boff;
   } addr_fields_t;

   // One tag RAM word
   // Valid bits live in flops next to the RAM so that reset can clear them
   typedef struct packed {
      logic                 dirty;
      logic [TAG_WIDTH-1:0] tag;
   } way_entry_t;

endpackage

// ==== verilog/dcache_sram.sv ====
/*
 * Generic single-clock RAM
 * One synchronous read port and one write port, with write-to-read
 * bypass on an address match
 */
`timescale 1ns/1ps

module dcache_sram #(
   parameter int ADDR_W = 6,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic              we_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic [DATA_W-1:0] rdata_o
);

   // Storage array
   logic [DATA_W-1:0] mem [1 << ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      // Same-cycle write wins so the reader never sees stale data
      if (we_i && waddr_i == raddr_i) begin
         rdata_o <= wdata_i;
      end else begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

// ==== verilog/dcache_tag_array.sv ====
/*
 * Data cache tag array
 * Tag RAM per way plus valid and LRU flops; compares the looked-up
 * tag against both ways and names the LRU way as victim
 */
`timescale 1ns/1ps

module dcache_tag_array #(
   parameter int RAM_AW = dcache_geom_pkg::SET_WIDTH,
   parameter int RAM_DW = $bits(dcache_geom_pkg::way_entry_t)
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  dcache_geom_pkg::addr_fields_t         rd_addr_i,
   input  logic [dcache_geom_pkg::SET_WIDTH-1:0] wr_set_i,
   input  logic                                  wr_way_i,
   input  logic [dcache_geom_pkg::TAG_WIDTH-1:0] wr_tag_i,
   input  logic                                  tag_wr_i,
   input  logic                                  dirty_set_i,
   input  logic                                  clear_set_i,
   input  logic                                  touch_i,
   output logic                                  hit_o,
   output logic                                  hit_way_o,
   output logic                                  victim_way_o,
   output logic                                  victim_dirty_o,
   output logic [dcache_geom_pkg::TAG_WIDTH-1:0] victim_tag_o
);
   import dcache_geom_pkg::*;

   localparam int NUM_SETS = 1 << SET_WIDTH;

   // Valid per way and set, LRU way index per set
   logic [NUM_SETS-1:0]  valid_q [NUM_WAYS];
   logic [NUM_SETS-1:0]  lru_q;
   // Entries read out of both ways
   way_entry_t           ent [NUM_WAYS];
   way_entry_t           ent_wdata;
   // Lookup address, aligned with RAM output
   logic [TAG_WIDTH-1:0] lk_tag_q;
   logic [SET_WIDTH-1:0] lk_set_q;
   logic [NUM_WAYS-1:0]  way_hit;

   // Refill tag write clears dirty, store hit sets it
   assign ent_wdata = '{dirty: dirty_set_i, tag: wr_tag_i};

   // ****************************************
   // Tag RAMs and per-way compare
   // ****************************************
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sram #(
         .ADDR_W (RAM_AW),
         .DATA_W (RAM_DW)
      ) u_tag_ram (
         .clk     (clk),
         .raddr_i (rd_addr_i.set),
         .waddr_i (wr_set_i),
         .we_i    ((tag_wr_i || dirty_set_i) && wr_way_i == 1'(w)),
         .wdata_i (ent_wdata),
         .rdata_o (ent[w])
      );

      assign way_hit[w] = valid_q[w][lk_set_q] && ent[w].tag == lk_tag_q;
   end

   always_ff @(posedge clk) begin
      lk_tag_q <= rd_addr_i.tag;
      lk_set_q <= rd_addr_i.set;
   end

   // ****************************************
   // Valid and LRU state
   // ****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '{default: '0};
         lru_q   <= '0;
      end else begin
         if (tag_wr_i) begin
            valid_q[wr_way_i][wr_set_i] <= 1'b1;
         end
         // Other way becomes least recently used
         if (touch_i) begin
            lru_q[wr_set_i] <= ~wr_way_i;
         end
         if (clear_set_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               valid_q[w][wr_set_i] <= 1'b0;
            end
            lru_q[wr_set_i] <= 1'b0;
         end
      end
   end

   // Lookup results
   assign hit_o     = |way_hit;
   assign hit_way_o = way_hit[1];

   // Victim is the LRU way, dirty only if it still holds a valid line
   assign victim_way_o   = lru_q[lk_set_q];
   assign victim_dirty_o = valid_q[victim_way_o][lk_set_q] && ent[victim_way_o].dirty;
   assign victim_tag_o   = ent[victim_way_o].tag;

endmodule

// ==== verilog/dcache_top.sv ====
/*
 * Two-way write-back data cache
 * Joins the controller with the tag and data arrays and
 * sizes the RAMs
 */
`timescale 1ns/1ps

module dcache_top (
   input  logic                                   clk,
   input  logic                                   rst,
   // CPU side
   input  logic                                   cpu_req_valid_i,
   input  dcache_bus_pkg::cpu_req_t               cpu_req_i,
   output logic                                   cpu_busy_o,
   output logic                                   cpu_ack_o,
   output logic [dcache_geom_pkg::DATA_WIDTH-1:0] cpu_rdata_o,
   // Memory side
   output logic                                   mem_wr_valid_o,
   output dcache_bus_pkg::mem_wr_t                mem_wr_o,
   output logic                                   mem_rd_req_o,
   output logic [dcache_geom_pkg::ADDR_WIDTH-1:0] mem_rd_addr_o,
   input  logic                                   mem_rd_valid_i,
   input  logic [dcache_geom_pkg::DATA_WIDTH-1:0] mem_rd_data_i
);
   import dcache_geom_pkg::*;

   // RAM sizes
   localparam int TAG_RAM_AW  = SET_WIDTH;
   localparam int TAG_RAM_DW  = $bits(way_entry_t);
   localparam int DATA_RAM_AW = SET_WIDTH + WORD_SEL_WIDTH;
   localparam int DATA_RAM_DW = DATA_WIDTH;

   // Controller to arrays
   addr_fields_t              rd_addr;
   logic                      way;
   logic [SET_WIDTH-1:0]      wr_set;
   logic [TAG_WIDTH-1:0]      wr_tag;
   logic                      tag_wr;
   logic                      dirty_set;
   logic                      clear_set;
   logic                      touch;
   logic                      data_wr;
   logic [WORD_SEL_WIDTH-1:0] data_wr_word;
   logic [DATA_WIDTH-1:0]     data_wr_data;
   logic [3:0]                data_wr_bsel;
   // Arrays to controller
   logic                      hit;
   logic                      hit_way;
   logic                      victim_way;
   logic                      victim_dirty;
   logic [TAG_WIDTH-1:0]      victim_tag;
   logic [DATA_WIDTH-1:0]     data_rdata;

   dcache_ctrl u_dcache_ctrl (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_valid_i (cpu_req_valid_i),
      .cpu_req_i       (cpu_req_i),
      .cpu_busy_o      (cpu_busy_o),
      .cpu_ack_o       (cpu_ack_o),
      .cpu_rdata_o     (cpu_rdata_o),
      .rd_addr_o       (rd_addr),
      .way_o           (way),
      .wr_set_o        (wr_set),
      .wr_tag_o        (wr_tag),
      .tag_wr_o        (tag_wr),
      .dirty_set_o     (dirty_set),
      .clear_set_o     (clear_set),
      .touch_o         (touch),
      .data_wr_o       (data_wr),
      .data_wr_word_o  (data_wr_word),
      .data_wr_data_o  (data_wr_data),
      .data_wr_bsel_o  (data_wr_bsel),
      .hit_i           (hit),
      .hit_way_i       (hit_way),
      .victim_way_i    (victim_way),
      .victim_dirty_i  (victim_dirty),
      .victim_tag_i    (victim_tag),
      .data_rdata_i    (data_rdata),
      .mem_wr_valid_o  (mem_wr_valid_o),
      .mem_wr_o        (mem_wr_o),
      .mem_rd_req_o    (mem_rd_req_o),
      .mem_rd_addr_o   (mem_rd_addr_o),
      .mem_rd_valid_i  (mem_rd_valid_i),
      .mem_rd_data_i   (mem_rd_data_i)
   );

   dcache_tag_array #(
      .RAM_AW (TAG_RAM_AW),
      .RAM_DW (TAG_RAM_DW)
   ) u_dcache_tag_array (
      .clk            (clk),
      .rst            (rst),
      .rd_addr_i      (rd_addr),
      .wr_set_i       (wr_set),
      .wr_way_i       (way),
      .wr_tag_i       (wr_tag),
      .tag_wr_i       (tag_wr),
      .dirty_set_i    (dirty_set),
      .clear_set_i    (clear_set),
      .touch_i        (touch),
      .hit_o          (hit),
      .hit_way_o      (hit_way),
      .victim_way_o   (victim_way),
      .victim_dirty_o (victim_dirty),
      .victim_tag_o   (victim_tag)
   );

   // Same way drives the output select and the write port
   dcache_data_array #(
      .RAM_AW (DATA_RAM_AW),
      .RAM_DW (DATA_RAM_DW)
   ) u_dcache_data_array (
      .clk       (clk),
      .rd_set_i  (rd_addr.set),
      .rd_word_i (rd_addr.word),
      .out_way_i (way),
      .wr_en_i   (data_wr),
      .wr_way_i  (way),
      .wr_set_i  (wr_set),
      .wr_word_i (data_wr_word),
      .wr_data_i (data_wr_data),
      .wr_bsel_i (data_wr_bsel),
      .rdata_o   (data_rdata)
   );

endmodule
